/* project.f */
src/mem_pkg.sv
src/lsu_ctrl.sv
src/load_formatter.sv
src/mem_stage.sv
src/data_ram.sv
src/wb_stage.sv
src/mem_subsys.sv
tests/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - src/mem_pkg.sv
  - src/lsu_ctrl.sv
  - src/load_formatter.sv
  - src/mem_stage.sv
  - src/data_ram.sv
  - src/wb_stage.sv
  - src/mem_subsys.sv
  - target: test
    files:
      - tests/tb_mem_subsys.sv

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys import mem_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  localparam int N_DW = 4;
  localparam int N_MIX = 16;
  localparam int N_BP = 40;
  localparam int N_INSTR = N_DW * 8 + 5 + 1 + N_MIX + N_BP;

  typedef struct packed {
    reg_t       pc;
    logic [4:0] rd;
    logic       wr;
    reg_t       data;
  } commit_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       ex_to_mem_valid;
  ex_to_mem_t ex_to_mem;
  logic       mem_allowin;
  logic       wb_stall;
  mem_fwd_t   mem_fwd;
  logic       commit_valid;
  reg_t       commit_pc;
  logic [4:0] commit_rd;
  reg_t       commit_data;
  logic [4:0] rs_addr;
  reg_t       rs_data;

  logic [7:0] mem_mirror [2**(RAM_AW+3)];
  reg_t       rf_mirror [32];
  commit_t    exp_q [$];
  reg_t       stored_q [$];
  reg_t       pc_next;
  logic       stall_on;
  int         errors;
  int         n_issued;
  int         n_commits;

  mem_subsys dut (
    .clk             (clk),
    .rst             (rst),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .mem_allowin     (mem_allowin),
    .wb_stall        (wb_stall),
    .mem_fwd         (mem_fwd),
    .commit_valid    (commit_valid),
    .commit_pc       (commit_pc),
    .commit_rd       (commit_rd),
    .commit_data     (commit_data),
    .rs_addr         (rs_addr),
    .rs_data         (rs_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // reference model helpers.
  ////////////////////////////////////////

  function automatic int load_bytes(input load_op_e op);
    case (op)
      LB, LBU: return 1;
      LH, LHU: return 2;
      LW, LWU: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic int store_bytes(input store_op_e op);
    case (op)
      SB: return 1;
      SH: return 2;
      SW: return 4;
      default: return 8;
    endcase
  endfunction

  // little-endian gather from the mirror, then extend.
  function automatic reg_t load_expect(input load_op_e op, input reg_t addr);
    int   n;
    reg_t v;
    n = load_bytes(op);
    v = '0;
    for (int i = n - 1; i >= 0; i--) begin
      v = (v << 8) | reg_t'(mem_mirror[addr[RAM_AW+2:0] + i]);
    end
    if ((op == LB || op == LH || op == LW) && v[8*n-1]) begin
      v = v | ~((reg_t'(1) << (8 * n)) - 1);
    end
    return v;
  endfunction

  function automatic reg_t aligned_off(input int n);
    return reg_t'(($urandom % (8 / n)) * n);
  endfunction

  function automatic logic [4:0] rand_rd();
    return 5'(1 + $urandom % 31);
  endfunction

  function automatic reg_t rand_dw_addr();
    return reg_t'($urandom % (2**RAM_AW)) << 3;
  endfunction

  function automatic ex_to_mem_t make_rec(input load_op_e lop, input store_op_e sop,
                                          input reg_t sdata, input reg_t addr,
                                          input reg_t csr, input wb_sel_e sel,
                                          input logic [4:0] rd, input logic wr);
    ex_to_mem_t r;
    r.pc = '0;
    r.load_op = lop;
    r.store_op = sop;
    r.store_data = sdata;
    r.addr = addr;
    r.csr_rd_data = csr;
    r.wb_sel = sel;
    r.rd = rd;
    r.rd_wr_ena = wr;
    return r;
  endfunction

  task automatic report_mismatch(input string name, input reg_t got, input reg_t exp);
    $display("MISMATCH %s: got %h expected %h", name, got, exp);
    errors++;
  endtask

  // the instruction just taken is the one decode sees.
  task automatic compare_fwd(input ex_to_mem_t rec);
    if (mem_fwd.valid !== 1'b1) begin
      report_mismatch("mem_fwd.valid", reg_t'(mem_fwd.valid), 64'h1);
    end
    if (mem_fwd.rd !== rec.rd) begin
      report_mismatch("mem_fwd.rd", reg_t'(mem_fwd.rd), reg_t'(rec.rd));
    end
    if (mem_fwd.rd_wr_ena !== rec.rd_wr_ena) begin
      report_mismatch("mem_fwd.rd_wr_ena", reg_t'(mem_fwd.rd_wr_ena), reg_t'(rec.rd_wr_ena));
    end
    if (mem_fwd.wb_sel !== rec.wb_sel) begin
      report_mismatch("mem_fwd.wb_sel", reg_t'(mem_fwd.wb_sel), reg_t'(rec.wb_sel));
    end
    if (mem_fwd.ex_data !== rec.addr) begin
      report_mismatch("mem_fwd.ex_data", mem_fwd.ex_data, rec.addr);
    end
  endtask

  ////////////////////////////////////////
  // driver and commit monitor.
  ////////////////////////////////////////

  // called on a falling edge, returns on the falling edge after acceptance.
  task automatic issue(input ex_to_mem_t rec);
    logic    taken;
    commit_t e;
    int      n;
    rec.pc = pc_next;
    ex_to_mem = rec;
    ex_to_mem_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      if (stall_on) begin
        wb_stall = ($urandom % 3) == 0;
      end
      #1;
      taken = mem_allowin;
      @(negedge clk);
    end
    ex_to_mem_valid = 1'b0;
    compare_fwd(rec);
    e.pc = rec.pc;
    e.rd = rec.rd;
    e.wr = rec.rd_wr_ena;
    case (rec.wb_sel)
      WB_MEM: e.data = load_expect(rec.load_op, rec.addr);
      WB_CSR: e.data = rec.csr_rd_data;
      default: e.data = rec.addr;
    endcase
    if (rec.store_op != ST_NONE) begin
      n = store_bytes(rec.store_op);
      for (int i = 0; i < n; i++) begin
        mem_mirror[rec.addr[RAM_AW+2:0] + i] = rec.store_data[8*i +: 8];
      end
    end
    exp_q.push_back(e);
    n_issued++;
    pc_next = pc_next + 4;
  endtask

  task automatic check_commit();
    commit_t e;
    if (exp_q.size() == 0) begin
      $display("unexpected commit of pc %h while nothing was outstanding", commit_pc);
      errors++;
    end else begin
      e = exp_q.pop_front();
      n_commits++;
      if (commit_pc !== e.pc) report_mismatch("commit_pc", commit_pc, e.pc);
      if (commit_rd !== e.rd) report_mismatch("commit_rd", reg_t'(commit_rd), reg_t'(e.rd));
      if (commit_data !== e.data) report_mismatch("commit_data", commit_data, e.data);
      if (e.wr && e.rd != 5'd0) rf_mirror[e.rd] = e.data;
    end
  endtask

  always @(negedge clk) begin
    if (!rst && commit_valid) begin
      check_commit();
    end
  end

  task automatic drain();
    stall_on = 1'b0;
    wb_stall = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic check_regs();
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      rs_addr = 5'(i);
      #1;
      if (rs_data !== rf_mirror[i]) begin
        $display("MISMATCH rs_data[x%0d]: got %h expected %h", i, rs_data, rf_mirror[i]);
        errors++;
      end
    end
  endtask

  task automatic issue_random();
    int        kind;
    reg_t      a;
    load_op_e  op;
    store_op_e sop;
    kind = $urandom % 5;
    if (stored_q.size() == 0) kind = 3;
    case (kind)
      0: issue(make_rec(LD_NONE, ST_NONE, '0, {$urandom, $urandom}, '0, WB_EX,
                        rand_rd(), 1'b1));
      1: issue(make_rec(LD_NONE, ST_NONE, '0, {$urandom, $urandom}, {$urandom, $urandom},
                        WB_CSR, rand_rd(), 1'b1));
      2: begin
        op = load_op_e'(1 + $urandom % 7);
        a = stored_q[$urandom % stored_q.size()] + aligned_off(load_bytes(op));
        issue(make_rec(op, ST_NONE, '0, a, '0, WB_MEM, rand_rd(), 1'b1));
      end
      3: begin
        a = rand_dw_addr();
        issue(make_rec(LD_NONE, SD, {$urandom, $urandom}, a, '0, WB_EX, 5'd0, 1'b0));
        stored_q.push_back(a);
      end
      default: begin
        sop = store_op_e'(1 + $urandom % 3);
        a = stored_q[$urandom % stored_q.size()] + aligned_off(store_bytes(sop));
        issue(make_rec(LD_NONE, sop, {$urandom, $urandom}, a, '0, WB_EX, 5'd0, 1'b0));
      end
    endcase
  endtask

  ////////////////////////////////////////
  // directed tests.
  ////////////////////////////////////////

  task automatic test_reset();
    if (commit_valid !== 1'b0) report_mismatch("commit_valid", reg_t'(commit_valid), '0);
    if (mem_fwd.valid !== 1'b0) report_mismatch("mem_fwd.valid", reg_t'(mem_fwd.valid), '0);
    if (mem_allowin !== 1'b1) report_mismatch("mem_allowin", reg_t'(mem_allowin), 64'h1);
    check_regs();
  endtask

  task automatic test_store_load();
    reg_t     base [N_DW];
    load_op_e op;
    for (int i = 0; i < N_DW; i++) begin
      base[i] = rand_dw_addr();
      issue(make_rec(LD_NONE, SD, {$urandom, $urandom}, base[i], '0, WB_EX, 5'd0, 1'b0));
      stored_q.push_back(base[i]);
    end
    for (int i = 0; i < N_DW; i++) begin
      for (int k = 1; k < 8; k++) begin
        op = load_op_e'(k);
        issue(make_rec(op, ST_NONE, '0, base[i] + aligned_off(load_bytes(op)), '0, WB_MEM,
                       rand_rd(), 1'b1));
      end
    end
    drain();
    check_regs();
  endtask

  // upper store_data bits are junk and must not reach memory.
  task automatic test_store_size();
    reg_t       a;
    logic [4:0] rd;
    a = rand_dw_addr();
    rd = rand_rd();
    issue(make_rec(LD_NONE, SD, 64'h0123_4567_89ab_cdef, a, '0, WB_EX, 5'd0, 1'b0));
    issue(make_rec(LD_NONE, SB, 64'hffff_ffff_ffff_ff5a, a + 5, '0, WB_EX, 5'd0, 1'b0));
    issue(make_rec(LD_NONE, SH, 64'hdead_beef_0000_c3a5, a + 6, '0, WB_EX, 5'd0, 1'b0));
    issue(make_rec(LD_NONE, SW, 64'h7777_7777_1234_5678, a, '0, WB_EX, 5'd0, 1'b0));
    issue(make_rec(LD, ST_NONE, '0, a, '0, WB_MEM, rd, 1'b1));
    stored_q.push_back(a);
    drain();
    @(negedge clk);
    rs_addr = rd;
    #1;
    if (rs_data !== 64'hc3a5_5a67_1234_5678) begin
      report_mismatch("rs_data", rs_data, 64'hc3a5_5a67_1234_5678);
    end
  endtask

  task automatic test_nonmem();
    issue(make_rec(LD_NONE, ST_NONE, '0, {$urandom, $urandom}, '0, WB_EX, 5'd0, 1'b1));
    for (int i = 0; i < N_MIX; i++) begin
      issue_random();
    end
    drain();
    check_regs();
  endtask

  task automatic test_backpressure();
    stall_on = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      issue_random();
    end
    drain();
    check_regs();
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog.
  ////////////////////////////////////////

  initial begin
    void'($urandom(62));
    rst = 1'b1;
    ex_to_mem_valid = 1'b0;
    ex_to_mem = '0;
    wb_stall = 1'b0;
    rs_addr = 5'd0;
    stall_on = 1'b0;
    pc_next = 64'h1000;
    errors = 0;
    n_issued = 0;
    n_commits = 0;
    for (int i = 0; i < 32; i++) begin
      rf_mirror[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_store_load();
    test_store_size();
    test_nonmem();
    test_backpressure();
    if (n_commits != n_issued) begin
      $display("%0d instructions issued but %0d committed", n_issued, n_commits);
      errors++;
    end
    $display("errors: %0d, issued: %0d, committed: %0d", errors, n_issued, n_commits);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (RST_CYCLES + 200 * N_INSTR));
    $display("timeout: run did not finish, %0d commits still outstanding", exp_q.size());
    $display("errors: %0d, issued: %0d, committed: %0d", errors, n_issued, n_commits);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* src/mem_subsys.sv */
`timescale 1ns/1ns

module mem_subsys import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ex_to_mem_valid,
  input  ex_to_mem_t ex_to_mem,
  output logic       mem_allowin,
  input  logic       wb_stall,
  output mem_fwd_t   mem_fwd,
  output logic       commit_valid,
  output reg_t       commit_pc,
  output logic [4:0] commit_rd,
  output reg_t       commit_data,
  input  logic [4:0] rs_addr,
  output reg_t       rs_data
);

  logic       mem_to_wb_valid;
  mem_to_wb_t mem_to_wb;
  logic       wb_allowin;
  logic       mem_valid;
  mem_req_t   mem_req;
  logic       mem_ready;
  reg_t       mem_rdata;

  mem_stage u_mem_stage (
    .clk             (clk),
    .rst             (rst),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .mem_allowin     (mem_allowin),
    .mem_to_wb_valid (mem_to_wb_valid),
    .mem_to_wb       (mem_to_wb),
    .wb_allowin      (wb_allowin),
    .mem_fwd         (mem_fwd),
    .mem_valid       (mem_valid),
    .mem_req         (mem_req),
    .mem_ready       (mem_ready),
    .mem_rdata       (mem_rdata)
  );

  data_ram u_data_ram (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  wb_stage u_wb_stage (
    .clk             (clk),
    .rst             (rst),
    .wb_stall        (wb_stall),
    .wb_allowin      (wb_allowin),
    .mem_to_wb_valid (mem_to_wb_valid),
    .mem_to_wb       (mem_to_wb),
    .commit_valid    (commit_valid),
    .commit_pc       (commit_pc),
    .commit_rd       (commit_rd),
    .commit_data     (commit_data),
    .rs_addr         (rs_addr),
    .rs_data         (rs_data)
  );

endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ns

module wb_stage import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wb_stall,
  output logic       wb_allowin,
  input  logic       mem_to_wb_valid,
  input  mem_to_wb_t mem_to_wb,
  output logic       commit_valid,
  output reg_t       commit_pc,
  output logic [4:0] commit_rd,
  output reg_t       commit_data,
  input  logic [4:0] rs_addr,
  output reg_t       rs_data
);

  mem_to_wb_t r;
  reg_t       result;
  reg_t       rf [32];

  assign wb_allowin = !wb_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= mem_to_wb_valid && wb_allowin;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_to_wb_valid && wb_allowin) begin
      r <= mem_to_wb;
    end
  end

  always_comb begin
    case (r.wb_sel)
      WB_MEM: result = r.mem_data;
      WB_CSR: result = r.csr_data;
      default: result = r.ex_data;
    endcase
  end

  assign commit_pc = r.pc;
  assign commit_rd = r.rd;
  assign commit_data = result;

  // architectural registers come up zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (commit_valid && r.rd_wr_ena && (r.rd != 5'd0)) begin
      rf[r.rd] <= result;
    end
  end

  assign rs_data = (rs_addr == 5'd0) ? '0 : rf[rs_addr];

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ns

module data_ram import mem_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_valid,
  input  mem_req_t mem_req,
  output logic     mem_ready,
  output reg_t     mem_rdata
);

  reg_t mem [2**RAM_AW];

  logic [RAM_AW-1:0] idx;
  logic [2:0]        off;
  logic [7:0]        size_be;
  logic [7:0]        be;
  reg_t              wdata_sh;
  logic [2:0]        low_mask;
  logic [7:0]        lfsr;
  logic              active;
  logic [1:0]        wait_cnt;

  assign idx = mem_req.addr[RAM_AW+2:3];
  assign off = mem_req.addr[2:0];

  always_comb begin
    case (mem_req.size)
      SIZE_B: begin
        size_be = 8'h01;
        low_mask = 3'b000;
      end
      SIZE_H: begin
        size_be = 8'h03;
        low_mask = 3'b001;
      end
      SIZE_W: begin
        size_be = 8'h0f;
        low_mask = 3'b011;
      end
      default: begin
        size_be = 8'hff;
        low_mask = 3'b111;
      end
    endcase
  end

  assign be = size_be << off;
  assign wdata_sh = mem_req.wdata << {off, 3'b000};
  assign mem_rdata = mem[idx] >> {off, 3'b000};

  ////////////////////////////////////////
  // wait states.
  ////////////////////////////////////////

  // first cycle of a request uses the lfsr directly, later ones count down.
  assign mem_ready = mem_valid && (active ? (wait_cnt == 2'd0) : (lfsr[1:0] == 2'd0));

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= LFSR_SEED;
      active <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (mem_valid && mem_ready) begin
        active <= 1'b0;
      end else if (mem_valid && !active) begin
        active <= 1'b1;
        wait_cnt <= lfsr[1:0] - 2'd1;
      end else if (active) begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  ////////////////////////////////////////
  // byte-lane writes.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (mem_valid && mem_ready && mem_req.write) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
        end
      end
    end
  end

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_valid |-> (off & low_mask) == 3'b000);

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ex_to_mem_valid,
  input  ex_to_mem_t ex_to_mem,
  output logic       mem_allowin,
  output logic       mem_to_wb_valid,
  output mem_to_wb_t mem_to_wb,
  input  logic       wb_allowin,
  output mem_fwd_t   mem_fwd,
  output logic       mem_valid,
  output mem_req_t   mem_req,
  input  logic       mem_ready,
  input  reg_t       mem_rdata
);

  logic       stage_valid;
  ex_to_mem_t cur;
  logic       accept;
  logic       next_is_mem;
  logic       cur_is_mem;
  logic       ready_go;
  logic       handshake;
  logic       finish;
  reg_t       load_data;

  ////////////////////////////////////////
  // pipeline register and handshake.
  ////////////////////////////////////////

  assign accept = ex_to_mem_valid && mem_allowin;
  assign next_is_mem = (ex_to_mem.load_op != LD_NONE) || (ex_to_mem.store_op != ST_NONE);
  assign cur_is_mem = (cur.load_op != LD_NONE) || (cur.store_op != ST_NONE);

  assign ready_go = !cur_is_mem || finish;
  assign mem_allowin = !stage_valid || (ready_go && wb_allowin);
  assign mem_to_wb_valid = stage_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (mem_allowin) begin
      stage_valid <= ex_to_mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur <= ex_to_mem;
    end
  end

  ////////////////////////////////////////
  // memory access.
  ////////////////////////////////////////

  lsu_ctrl u_lsu_ctrl (
    .clk         (clk),
    .rst         (rst),
    .accept      (accept),
    .next_is_mem (next_is_mem),
    .cur         (cur),
    .mem_valid   (mem_valid),
    .mem_req     (mem_req),
    .handshake   (handshake),
    .finish      (finish),
    .mem_ready   (mem_ready)
  );

  load_formatter u_load_formatter (
    .clk       (clk),
    .capture   (handshake),
    .load_op   (cur.load_op),
    .rdata     (mem_rdata),
    .load_data (load_data)
  );

  ////////////////////////////////////////
  // outgoing records.
  ////////////////////////////////////////

  assign mem_to_wb.pc = cur.pc;
  assign mem_to_wb.rd = cur.rd;
  assign mem_to_wb.rd_wr_ena = cur.rd_wr_ena;
  assign mem_to_wb.wb_sel = cur.wb_sel;
  assign mem_to_wb.ex_data = cur.addr;
  assign mem_to_wb.mem_data = load_data;
  assign mem_to_wb.csr_data = cur.csr_rd_data;

  // decode sees the instruction as soon as it sits here.
  assign mem_fwd.valid = stage_valid;
  assign mem_fwd.rd = cur.rd;
  assign mem_fwd.rd_wr_ena = cur.rd_wr_ena;
  assign mem_fwd.wb_sel = cur.wb_sel;
  assign mem_fwd.ex_data = cur.addr;

endmodule

/* src/load_formatter.sv */
`timescale 1ns/1ns

module load_formatter import mem_pkg::*; (
  input  logic     clk,
  input  logic     capture,
  input  load_op_e load_op,
  input  reg_t     rdata,
  output reg_t     load_data
);

  reg_t ext_data;

  // rdata already sits at bit 0.
  always_comb begin
    case (load_op)
      LB: ext_data = {{56{rdata[7]}}, rdata[7:0]};
      LH: ext_data = {{48{rdata[15]}}, rdata[15:0]};
      LW: ext_data = {{32{rdata[31]}}, rdata[31:0]};
      LBU: ext_data = {56'b0, rdata[7:0]};
      LHU: ext_data = {48'b0, rdata[15:0]};
      LWU: ext_data = {32'b0, rdata[31:0]};
      default: ext_data = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      load_data <= ext_data;
    end
  end

endmodule

/* src/lsu_ctrl.sv */
`timescale 1ns/1ns

module lsu_ctrl import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       accept,
  input  logic       next_is_mem,
  input  ex_to_mem_t cur,
  output logic       mem_valid,
  output mem_req_t   mem_req,
  output logic       handshake,
  output logic       finish,
  input  logic       mem_ready
);

  lsu_state_e state;
  lsu_state_e state_nxt;
  mem_size_e  size;
  reg_t       wdata;

  ////////////////////////////////////////
  // request state machine.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: if (accept && next_is_mem) state_nxt = ADDR;
      ADDR: if (handshake) state_nxt = RETN;
      RETN: if (accept) state_nxt = next_is_mem ? ADDR : IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  assign mem_valid = (state == ADDR);
  assign handshake = mem_valid && mem_ready;
  // result held until the next acceptance.
  assign finish = (state == RETN);

  ////////////////////////////////////////
  // access size and store data.
  ////////////////////////////////////////

  always_comb begin
    if (cur.store_op != ST_NONE) begin
      case (cur.store_op)
        SB: size = SIZE_B;
        SH: size = SIZE_H;
        SW: size = SIZE_W;
        default: size = SIZE_D;
      endcase
    end else begin
      case (cur.load_op)
        LB, LBU: size = SIZE_B;
        LH, LHU: size = SIZE_H;
        LW, LWU: size = SIZE_W;
        default: size = SIZE_D;
      endcase
    end
  end

  always_comb begin
    case (size)
      SIZE_B: wdata = {56'b0, cur.store_data[7:0]};
      SIZE_H: wdata = {48'b0, cur.store_data[15:0]};
      SIZE_W: wdata = {32'b0, cur.store_data[31:0]};
      default: wdata = cur.store_data;
    endcase
  end

  assign mem_req.write = (cur.store_op != ST_NONE);
  assign mem_req.addr = cur.addr;
  assign mem_req.wdata = wdata;
  assign mem_req.size = size;

  // the stage must hold its record until the memory takes it.
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

  ////////////////////////////////////////
  // widths and constants.
  ////////////////////////////////////////

  localparam int XLEN = 64;
  localparam int RAM_AW = 10;
  localparam logic [7:0] LFSR_SEED = 8'h5a;

  typedef logic [XLEN-1:0] reg_t;

  ////////////////////////////////////////
  // opcodes and states.
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    LD_NONE,
    LB,
    LH,
    LW,
    LD,
    LBU,
    LHU,
    LWU
  } load_op_e;

  typedef enum logic [2:0] {
    ST_NONE,
    SB,
    SH,
    SW,
    SD
  } store_op_e;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  typedef enum logic [1:0] {
    WB_EX,
    WB_MEM,
    WB_CSR
  } wb_sel_e;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RETN
  } lsu_state_e;

  ////////////////////////////////////////
  // records between stages.
  ////////////////////////////////////////

  typedef struct packed {
    reg_t      pc;
    load_op_e  load_op;
    store_op_e store_op;
    reg_t      store_data;
    reg_t      addr;         // alu result or effective address.
    reg_t      csr_rd_data;
    wb_sel_e   wb_sel;
    logic [4:0] rd;
    logic      rd_wr_ena;
  } ex_to_mem_t;

  typedef struct packed {
    reg_t       pc;
    logic [4:0] rd;
    logic       rd_wr_ena;
    wb_sel_e    wb_sel;
    reg_t       ex_data;
    reg_t       mem_data;
    reg_t       csr_data;
  } mem_to_wb_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] rd;
    logic       rd_wr_ena;
    wb_sel_e    wb_sel;
    reg_t       ex_data;
  } mem_fwd_t;

  typedef struct packed {
    logic      write;
    reg_t      addr;
    reg_t      wdata;
    mem_size_e size;
  } mem_req_t;

endpackage
